/* verilog/xif_pkg.sv */
// Shared XIF offload definitions
// Custom-0 opcode, funct3 codes, id width and the instruction word views
package xif_pkg;

  localparam int unsigned XIF_ID_W = 4;

  localparam logic [6:0] OPCODE_CUSTOM0 = 7'b0001011;

  // R-type codes have funct3 bit 2 clear
  localparam logic [2:0] F3_SATADD  = 3'b000;
  localparam logic [2:0] F3_ABSDIFF = 3'b001;
  localparam logic [2:0] F3_MINU    = 3'b010;
  // I-type codes
  localparam logic [2:0] F3_ROTRI   = 3'b100;
  localparam logic [2:0] F3_BREVI   = 3'b101;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } xif_rtype_s;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } xif_itype_s;

  // Same word, read as R-type or I-type by funct3 bit 2
  typedef union packed {
    xif_rtype_s r;
    xif_itype_s i;
  } xif_instr_u;

endpackage

/* verilog/xif_result_queue.sv */
// Result FIFO between coprocessor and adapter
module xif_result_queue #(
  parameter int unsigned QUEUE_DEPTH = 2
) (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic                         push_i,
  input  logic [xif_pkg::XIF_ID_W-1:0] push_id_i,
  input  logic [4:0]                   push_rd_i,
  input  logic                         push_we_i,
  input  logic [31:0]                  push_data_i,
  output logic                         full_o,
  output logic                         x_result_valid_o,
  input  logic                         x_result_ready_i,
  output logic [xif_pkg::XIF_ID_W-1:0] x_result_id_o,
  output logic [4:0]                   x_result_rd_o,
  output logic                         x_result_we_o,
  output logic [31:0]                  x_result_data_o
);

  localparam int unsigned PTR_W   = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int unsigned ENTRY_W = xif_pkg::XIF_ID_W + 5 + 1 + 32;

  logic [ENTRY_W-1:0] mem_q [QUEUE_DEPTH];
  logic [PTR_W-1:0]   wr_ptr_q;
  logic [PTR_W-1:0]   rd_ptr_q;
  logic [PTR_W:0]     count_q;
  logic               pop;

  assign full_o           = (count_q == QUEUE_DEPTH);
  assign x_result_valid_o = (count_q != '0);
  assign pop              = x_result_valid_o && x_result_ready_i;

  assign {x_result_id_o, x_result_rd_o, x_result_we_o, x_result_data_o} = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // Pointers wrap on their own for power-of-two depths
      if (push_i) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      count_q <= count_q + (PTR_W+1)'(push_i) - (PTR_W+1)'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) mem_q[wr_ptr_q] <= {push_id_i, push_rd_i, push_we_i, push_data_i};
  end

  a_no_push_full: assert property (@(posedge clk_i) disable iff (rst_i)
    push_i |-> !full_o);

endmodule

/* verilog/xif_copro_unit.sv */
// Custom-0 coprocessor
// Decode and accept check, arithmetic, commit tracking and result push
module xif_copro_unit #(
  parameter int unsigned NUM_RS = 3
) (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic                         x_issue_valid_i,
  output logic                         x_issue_ready_o,
  input  logic [1:0]                   x_issue_mode_i,
  input  logic [xif_pkg::XIF_ID_W-1:0] x_issue_id_i,
  input  logic [31:0]                  x_issue_instr_i,
  input  logic [NUM_RS-1:0][31:0]      x_issue_rs_i,
  input  logic [NUM_RS-1:0]            x_issue_rs_valid_i,
  output logic                         x_issue_accept_o,
  output logic                         x_issue_writeback_o,
  input  logic                         x_commit_valid_i,
  input  logic [xif_pkg::XIF_ID_W-1:0] x_commit_id_i,
  input  logic                         x_commit_kill_i,
  input  logic                         queue_full_i,
  output logic                         push_o,
  output logic [xif_pkg::XIF_ID_W-1:0] push_id_o,
  output logic [4:0]                   push_rd_o,
  output logic                         push_we_o,
  output logic [31:0]                  push_data_o
);

  xif_pkg::xif_instr_u          instr;
  logic                         is_itype;
  logic                         known_f3;
  logic                         issue_xfer;
  logic [31:0]                  op_a;
  logic [31:0]                  op_b;
  logic [32:0]                  sum;
  logic [63:0]                  rot;
  logic [31:0]                  op_res;
  logic                         pend_q;
  logic                         push_q;
  logic                         acc_q;
  logic [xif_pkg::XIF_ID_W-1:0] pend_id_q;
  logic [4:0]                   rd_q;
  logic [31:0]                  res_q;

  assign instr    = x_issue_instr_i;
  assign is_itype = instr.r.funct3[2];
  assign op_a     = x_issue_rs_i[0];
  assign op_b     = x_issue_rs_i[1];
  assign known_f3 = instr.r.funct3 inside {xif_pkg::F3_SATADD, xif_pkg::F3_ABSDIFF,
                                           xif_pkg::F3_MINU, xif_pkg::F3_ROTRI,
                                           xif_pkg::F3_BREVI};

  // Only user-level issue, R-type needs funct7 zero and both sources
  assign x_issue_accept_o = (instr.r.opcode == xif_pkg::OPCODE_CUSTOM0) && known_f3 &&
                            (is_itype || instr.r.funct7 == 7'd0) &&
                            x_issue_rs_valid_i[0] && (is_itype || x_issue_rs_valid_i[1]) &&
                            (x_issue_mode_i == 2'b00);
  assign x_issue_writeback_o = x_issue_accept_o;

  // One uncommitted instruction, and room for its result in the queue
  assign x_issue_ready_o = !pend_q && !push_q && !queue_full_i;
  assign issue_xfer      = x_issue_valid_i && x_issue_ready_o;

  always_comb begin
    sum    = {1'b0, op_a} + {1'b0, op_b};
    rot    = {op_a, op_a} >> instr.i.imm12[4:0];
    op_res = '0;
    case (instr.r.funct3)
      xif_pkg::F3_SATADD:  op_res = sum[32] ? '1 : sum[31:0];
      xif_pkg::F3_ABSDIFF: op_res = (op_a >= op_b) ? op_a - op_b : op_b - op_a;
      xif_pkg::F3_MINU:    op_res = (op_a < op_b) ? op_a : op_b;
      xif_pkg::F3_ROTRI:   op_res = rot[31:0];
      xif_pkg::F3_BREVI: begin
        for (int k = 0; k < 32; k++) op_res[k] = op_a[31-k];
      end
      default:             op_res = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pend_q <= 1'b0;
      push_q <= 1'b0;
    end else begin
      push_q <= 1'b0;
      if (issue_xfer) begin
        pend_q <= 1'b1;
      end else if (x_commit_valid_i && pend_q && x_commit_id_i == pend_id_q) begin
        pend_q <= 1'b0;
        push_q <= acc_q && !x_commit_kill_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_xfer) begin
      pend_id_q <= x_issue_id_i;
      acc_q     <= x_issue_accept_o;
      rd_q      <= instr.r.rd;
      res_q     <= op_res;
    end
  end

  assign push_o      = push_q;
  assign push_id_o   = pend_id_q;
  assign push_rd_o   = rd_q;
  assign push_we_o   = acc_q;
  assign push_data_o = res_q;

  a_commit_pending: assert property (@(posedge clk_i) disable iff (rst_i)
    x_commit_valid_i |-> pend_q && x_commit_id_i == pend_id_q);

endmodule

/* verilog/xif_version_adapter.sv */
// X-IF v0.2 to v1.0 field translation
// Also tracks which instruction ids are outstanding
module xif_version_adapter #(
  parameter int unsigned NUM_RS = 3
) (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic                           issue_valid_i,
  output logic                           issue_ready_o,
  input  logic [31:0]                    issue_instr_i,
  input  logic [31:0]                    issue_rs1_i,
  input  logic [31:0]                    issue_rs2_i,
  input  logic [xif_pkg::XIF_ID_W-1:0]   issue_id_i,
  output logic                           issue_accept_o,
  output logic                           issue_writeback_o,
  input  logic                           commit_valid_i,
  input  logic [xif_pkg::XIF_ID_W-1:0]   commit_id_i,
  input  logic                           commit_kill_i,
  output logic                           res_valid_o,
  input  logic                           res_ready_i,
  output logic [xif_pkg::XIF_ID_W-1:0]   res_id_o,
  output logic [4:0]                     res_rd_o,
  output logic                           res_we_o,
  output logic [31:0]                    res_data_o,
  output logic [2**xif_pkg::XIF_ID_W-1:0] id_busy_o,
  output logic                           x_issue_valid_o,
  input  logic                           x_issue_ready_i,
  output logic [1:0]                     x_issue_mode_o,
  output logic [xif_pkg::XIF_ID_W-1:0]   x_issue_id_o,
  output logic [31:0]                    x_issue_instr_o,
  output logic [NUM_RS-1:0][31:0]        x_issue_rs_o,
  output logic [NUM_RS-1:0]              x_issue_rs_valid_o,
  input  logic                           x_issue_accept_i,
  input  logic                           x_issue_writeback_i,
  output logic                           x_commit_valid_o,
  output logic [xif_pkg::XIF_ID_W-1:0]   x_commit_id_o,
  output logic                           x_commit_kill_o,
  input  logic                           x_result_valid_i,
  output logic                           x_result_ready_o,
  input  logic [xif_pkg::XIF_ID_W-1:0]   x_result_id_i,
  input  logic [4:0]                     x_result_rd_i,
  input  logic                           x_result_we_i,
  input  logic [31:0]                    x_result_data_i
);

  // Both sources always supplied, as if register_read were all ones
  localparam logic [1:0] REG_READ = 2'b11;

  logic [2**xif_pkg::XIF_ID_W-1:0] busy_q;

  assign x_issue_valid_o   = issue_valid_i;
  assign issue_ready_o     = x_issue_ready_i;
  assign x_issue_mode_o    = 2'b00;
  assign x_issue_id_o      = issue_id_i;
  assign x_issue_instr_o   = issue_instr_i;
  assign issue_accept_o    = x_issue_accept_i;
  assign issue_writeback_o = x_issue_writeback_i;

  // Third source, if present, is padded with zero and marked invalid
  always_comb begin
    x_issue_rs_o          = '0;
    x_issue_rs_o[0]       = issue_rs1_i;
    x_issue_rs_o[1]       = issue_rs2_i;
    x_issue_rs_valid_o    = '0;
    x_issue_rs_valid_o[1:0] = REG_READ;
  end

  assign x_commit_valid_o = commit_valid_i;
  assign x_commit_id_o    = commit_id_i;
  assign x_commit_kill_o  = commit_kill_i;

  // Single hart, so no hartid travels with the result
  assign res_valid_o      = x_result_valid_i;
  assign x_result_ready_o = res_ready_i;
  assign res_id_o         = x_result_id_i;
  assign res_rd_o         = x_result_rd_i;
  assign res_we_o         = x_result_we_i;
  assign res_data_o       = x_result_data_i;

  assign id_busy_o = busy_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q <= '0;
    end else begin
      if (issue_valid_i && x_issue_ready_i && x_issue_accept_i) busy_q[issue_id_i] <= 1'b1;
      if (commit_valid_i && commit_kill_i) busy_q[commit_id_i] <= 1'b0;
      if (x_result_valid_i && res_ready_i) busy_q[x_result_id_i] <= 1'b0;
    end
  end

  a_result_outstanding: assert property (@(posedge clk_i) disable iff (rst_i)
    x_result_valid_i && res_ready_i |-> busy_q[x_result_id_i]);

endmodule

/* verilog/xif_offload_ctrl.sv */
// Offload control FSM
// Issues requests on the v0.2 side, sends commit or kill, returns responses
module xif_offload_ctrl (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic                         req_valid_i,
  output logic                         req_ready_o,
  input  logic [31:0]                  req_instr_i,
  input  logic [31:0]                  req_rs1_i,
  input  logic [31:0]                  req_rs2_i,
  input  logic [xif_pkg::XIF_ID_W-1:0] req_id_i,
  input  logic                         req_kill_i,
  output logic                         rsp_valid_o,
  output logic [xif_pkg::XIF_ID_W-1:0] rsp_id_o,
  output logic                         rsp_accept_o,
  output logic                         rsp_killed_o,
  output logic                         rsp_we_o,
  output logic [4:0]                   rsp_rd_o,
  output logic [31:0]                  rsp_data_o,
  output logic                         issue_valid_o,
  input  logic                         issue_ready_i,
  output logic [31:0]                  issue_instr_o,
  output logic [31:0]                  issue_rs1_o,
  output logic [31:0]                  issue_rs2_o,
  output logic [xif_pkg::XIF_ID_W-1:0] issue_id_o,
  input  logic                         issue_accept_i,
  input  logic                         issue_writeback_i,
  output logic                         commit_valid_o,
  output logic [xif_pkg::XIF_ID_W-1:0] commit_id_o,
  output logic                         commit_kill_o,
  input  logic                         res_valid_i,
  output logic                         res_ready_o,
  input  logic [xif_pkg::XIF_ID_W-1:0] res_id_i,
  input  logic [4:0]                   res_rd_i,
  input  logic                         res_we_i,
  input  logic [31:0]                  res_data_i,
  input  logic [2**xif_pkg::XIF_ID_W-1:0] id_busy_i
);

  localparam logic [1:0] IDLE   = 2'd0;
  localparam logic [1:0] ISSUE  = 2'd1;
  localparam logic [1:0] COMMIT = 2'd2;

  logic [1:0]                    state_q;
  logic                          init_q;
  logic                          lrsp_q;
  logic [31:0]                   instr_q;
  logic [31:0]                   rs1_q;
  logic [31:0]                   rs2_q;
  logic [xif_pkg::XIF_ID_W-1:0]  id_q;
  logic                          kill_q;
  logic                          accept_q;
  logic [2**xif_pkg::XIF_ID_W-1:0] wb_mask_q;

  // Hold off one cycle after reset and while the id is still in flight
  assign req_ready_o = init_q && (state_q == IDLE) && !id_busy_i[req_id_i];

  assign issue_valid_o = (state_q == ISSUE);
  assign issue_instr_o = instr_q;
  assign issue_rs1_o   = rs1_q;
  assign issue_rs2_o   = rs2_q;
  assign issue_id_o    = id_q;

  assign commit_valid_o = (state_q == COMMIT);
  assign commit_id_o    = id_q;
  assign commit_kill_o  = kill_q || !accept_q;

  // Local strobe for rejected or killed ids wins over the result channel
  assign res_ready_o  = !lrsp_q;
  assign rsp_valid_o  = lrsp_q || res_valid_i;
  assign rsp_id_o     = lrsp_q ? id_q : res_id_i;
  assign rsp_accept_o = lrsp_q ? accept_q : 1'b1;
  assign rsp_killed_o = lrsp_q && kill_q;
  assign rsp_we_o     = !lrsp_q && res_we_i && wb_mask_q[res_id_i];
  assign rsp_rd_o     = lrsp_q ? 5'd0 : res_rd_i;
  assign rsp_data_o   = lrsp_q ? 32'd0 : res_data_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
      init_q  <= 1'b0;
      lrsp_q  <= 1'b0;
    end else begin
      init_q <= 1'b1;
      lrsp_q <= commit_valid_o && commit_kill_o;
      case (state_q)
        IDLE:    if (req_valid_i && req_ready_o) state_q <= ISSUE;
        ISSUE:   if (issue_ready_i) state_q <= COMMIT;
        default: state_q <= IDLE;
      endcase
    end
  end

  // Request and issue response payload
  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      instr_q <= req_instr_i;
      rs1_q   <= req_rs1_i;
      rs2_q   <= req_rs2_i;
      id_q    <= req_id_i;
      kill_q  <= req_kill_i;
    end
    if (issue_valid_o && issue_ready_i) begin
      accept_q          <= issue_accept_i;
      wb_mask_q[id_q]   <= issue_writeback_i;
    end
  end

  a_commit_after_issue: assert property (@(posedge clk_i) disable iff (rst_i)
    commit_valid_o |-> $past(issue_valid_o && issue_ready_i));

endmodule

/* verilog/xif_offload_top.sv */
// XIF offload subsystem top level
// Control, version adapter, coprocessor and result queue
module xif_offload_top #(
  parameter int unsigned NUM_RS      = 3,
  parameter int unsigned QUEUE_DEPTH = 2
) (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic                         req_valid_i,
  output logic                         req_ready_o,
  input  logic [31:0]                  req_instr_i,
  input  logic [31:0]                  req_rs1_i,
  input  logic [31:0]                  req_rs2_i,
  input  logic [xif_pkg::XIF_ID_W-1:0] req_id_i,
  input  logic                         req_kill_i,
  output logic                         rsp_valid_o,
  output logic [xif_pkg::XIF_ID_W-1:0] rsp_id_o,
  output logic                         rsp_accept_o,
  output logic                         rsp_killed_o,
  output logic                         rsp_we_o,
  output logic [4:0]                   rsp_rd_o,
  output logic [31:0]                  rsp_data_o
);

  // v0.2 side
  logic                           issue_valid, issue_ready, issue_accept, issue_writeback;
  logic [31:0]                    issue_instr, issue_rs1, issue_rs2;
  logic [xif_pkg::XIF_ID_W-1:0]   issue_id, commit_id, res_id;
  logic                           commit_valid, commit_kill;
  logic                           res_valid, res_ready, res_we;
  logic [4:0]                     res_rd;
  logic [31:0]                    res_data;
  logic [2**xif_pkg::XIF_ID_W-1:0] id_busy;

  // v1.0 side
  logic                           x_issue_valid, x_issue_ready, x_issue_accept;
  logic                           x_issue_writeback;
  logic [1:0]                     x_issue_mode;
  logic [xif_pkg::XIF_ID_W-1:0]   x_issue_id, x_commit_id, x_result_id;
  logic [31:0]                    x_issue_instr;
  logic [NUM_RS-1:0][31:0]        x_issue_rs;
  logic [NUM_RS-1:0]              x_issue_rs_valid;
  logic                           x_commit_valid, x_commit_kill;
  logic                           x_result_valid, x_result_ready, x_result_we;
  logic [4:0]                     x_result_rd;
  logic [31:0]                    x_result_data;

  // Coprocessor to queue
  logic                           push, push_we, queue_full;
  logic [xif_pkg::XIF_ID_W-1:0]   push_id;
  logic [4:0]                     push_rd;
  logic [31:0]                    push_data;

  xif_offload_ctrl u_ctrl (
    .clk_i, .rst_i,
    .req_valid_i, .req_ready_o, .req_instr_i, .req_rs1_i, .req_rs2_i, .req_id_i, .req_kill_i,
    .rsp_valid_o, .rsp_id_o, .rsp_accept_o, .rsp_killed_o, .rsp_we_o, .rsp_rd_o, .rsp_data_o,
    .issue_valid_o(issue_valid), .issue_ready_i(issue_ready), .issue_instr_o(issue_instr),
    .issue_rs1_o(issue_rs1), .issue_rs2_o(issue_rs2), .issue_id_o(issue_id),
    .issue_accept_i(issue_accept), .issue_writeback_i(issue_writeback),
    .commit_valid_o(commit_valid), .commit_id_o(commit_id), .commit_kill_o(commit_kill),
    .res_valid_i(res_valid), .res_ready_o(res_ready), .res_id_i(res_id), .res_rd_i(res_rd),
    .res_we_i(res_we), .res_data_i(res_data), .id_busy_i(id_busy)
  );

  xif_version_adapter #(.NUM_RS(NUM_RS)) u_adapter (
    .clk_i, .rst_i,
    .issue_valid_i(issue_valid), .issue_ready_o(issue_ready), .issue_instr_i(issue_instr),
    .issue_rs1_i(issue_rs1), .issue_rs2_i(issue_rs2), .issue_id_i(issue_id),
    .issue_accept_o(issue_accept), .issue_writeback_o(issue_writeback),
    .commit_valid_i(commit_valid), .commit_id_i(commit_id), .commit_kill_i(commit_kill),
    .res_valid_o(res_valid), .res_ready_i(res_ready), .res_id_o(res_id), .res_rd_o(res_rd),
    .res_we_o(res_we), .res_data_o(res_data), .id_busy_o(id_busy),
    .x_issue_valid_o(x_issue_valid), .x_issue_ready_i(x_issue_ready),
    .x_issue_mode_o(x_issue_mode), .x_issue_id_o(x_issue_id), .x_issue_instr_o(x_issue_instr),
    .x_issue_rs_o(x_issue_rs), .x_issue_rs_valid_o(x_issue_rs_valid),
    .x_issue_accept_i(x_issue_accept), .x_issue_writeback_i(x_issue_writeback),
    .x_commit_valid_o(x_commit_valid), .x_commit_id_o(x_commit_id),
    .x_commit_kill_o(x_commit_kill),
    .x_result_valid_i(x_result_valid), .x_result_ready_o(x_result_ready),
    .x_result_id_i(x_result_id), .x_result_rd_i(x_result_rd), .x_result_we_i(x_result_we),
    .x_result_data_i(x_result_data)
  );

  xif_copro_unit #(.NUM_RS(NUM_RS)) u_copro (
    .clk_i, .rst_i,
    .x_issue_valid_i(x_issue_valid), .x_issue_ready_o(x_issue_ready),
    .x_issue_mode_i(x_issue_mode), .x_issue_id_i(x_issue_id), .x_issue_instr_i(x_issue_instr),
    .x_issue_rs_i(x_issue_rs), .x_issue_rs_valid_i(x_issue_rs_valid),
    .x_issue_accept_o(x_issue_accept), .x_issue_writeback_o(x_issue_writeback),
    .x_commit_valid_i(x_commit_valid), .x_commit_id_i(x_commit_id),
    .x_commit_kill_i(x_commit_kill), .queue_full_i(queue_full),
    .push_o(push), .push_id_o(push_id), .push_rd_o(push_rd), .push_we_o(push_we),
    .push_data_o(push_data)
  );

  xif_result_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
    .clk_i, .rst_i,
    .push_i(push), .push_id_i(push_id), .push_rd_i(push_rd), .push_we_i(push_we),
    .push_data_i(push_data), .full_o(queue_full),
    .x_result_valid_o(x_result_valid), .x_result_ready_i(x_result_ready),
    .x_result_id_o(x_result_id), .x_result_rd_o(x_result_rd), .x_result_we_o(x_result_we),
    .x_result_data_o(x_result_data)
  );

endmodule

/* bench/tb_xif_offload.sv */
// Testbench for the XIF offload subsystem
// Reference model, directed and random requests, response checker and watchdog
module tb_xif_offload;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_DIRECTED = 17;
  localparam int NUM_RANDOM   = 64;
  localparam int NUM_REQS     = NUM_DIRECTED + NUM_RANDOM;
  localparam int NUM_IDS      = 2**xif_pkg::XIF_ID_W;
  localparam int WATCHDOG_CYC = NUM_REQS * 40 + 200;
  localparam logic [6:0] OPC  = xif_pkg::OPCODE_CUSTOM0;

  logic                         clk_i;
  logic                         rst_i;
  logic                         req_valid_i;
  logic                         req_ready_o;
  logic [31:0]                  req_instr_i;
  logic [31:0]                  req_rs1_i;
  logic [31:0]                  req_rs2_i;
  logic [xif_pkg::XIF_ID_W-1:0] req_id_i;
  logic                         req_kill_i;
  logic                         rsp_valid_o;
  logic [xif_pkg::XIF_ID_W-1:0] rsp_id_o;
  logic                         rsp_accept_o;
  logic                         rsp_killed_o;
  logic                         rsp_we_o;
  logic [4:0]                   rsp_rd_o;
  logic [31:0]                  rsp_data_o;

  // Expected response per id
  logic        exp_pending   [NUM_IDS];
  logic        exp_accept    [NUM_IDS];
  logic        exp_killed    [NUM_IDS];
  logic        exp_we        [NUM_IDS];
  logic [4:0]  exp_rd        [NUM_IDS];
  logic [31:0] exp_data      [NUM_IDS];
  logic        exp_fixed_lat [NUM_IDS];
  int          xfer_cyc      [NUM_IDS];

  int          cyc;
  int          pending_cnt;
  int          value_errs;
  int          missing_errs;
  int          reqs_sent;
  int          rsp_seen;
  logic        check_lat;
  logic [31:0] rng;

  xif_offload_top #(.NUM_RS(3), .QUEUE_DEPTH(2)) uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // Returns {accept, we, data}
  function automatic logic [33:0] ref_result(input logic [31:0] instr,
                                             input logic [31:0] a, input logic [31:0] b);
    logic [2:0]  f3;
    logic [4:0]  sh;
    logic [32:0] sum;
    logic        known;
    logic        acc;
    logic [31:0] d;
    f3  = instr[14:12];
    sh  = instr[24:20];
    sum = {1'b0, a} + {1'b0, b};
    known = (f3 == xif_pkg::F3_SATADD) || (f3 == xif_pkg::F3_ABSDIFF) ||
            (f3 == xif_pkg::F3_MINU) || (f3 == xif_pkg::F3_ROTRI) ||
            (f3 == xif_pkg::F3_BREVI);
    acc = (instr[6:0] == OPC) && known && (f3[2] || instr[31:25] == 7'd0);
    d = 32'd0;
    if (f3 == xif_pkg::F3_SATADD) d = sum[32] ? 32'hffff_ffff : sum[31:0];
    else if (f3 == xif_pkg::F3_ABSDIFF) d = (a > b) ? a - b : b - a;
    else if (f3 == xif_pkg::F3_MINU) d = (a < b) ? a : b;
    else if (f3 == xif_pkg::F3_ROTRI) d = (sh == 5'd0) ? a : ((a >> sh) | (a << (32 - int'(sh))));
    else if (f3 == xif_pkg::F3_BREVI) begin
      for (int k = 0; k < 32; k++) d[k] = a[31-k];
    end
    return {acc, acc, d};
  endfunction

  function automatic logic [31:0] enc_rtype(input logic [6:0] f7, input logic [2:0] f3,
                                            input logic [4:0] rd, input logic [6:0] op);
    return {f7, 5'd2, 5'd1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_itype(input logic [11:0] imm, input logic [2:0] f3,
                                            input logic [4:0] rd, input logic [6:0] op);
    return {imm, 5'd1, f3, rd, op};
  endfunction

  task automatic report_mismatch(input string what, input int id,
                                 input logic [31:0] got, input logic [31:0] exp);
    $display("[ERROR] %0t: id %0d %s got %0h expected %0h", $time, id, what, got, exp);
    value_errs++;
  endtask

  // Called in the time step of a rising edge, returns at the edge of the transfer
  task automatic send_req(input logic [31:0] instr, input logic [31:0] a, input logic [31:0] b,
                          input logic [xif_pkg::XIF_ID_W-1:0] id, input logic kill);
    req_valid_i <= 1'b1;
    req_instr_i <= instr;
    req_rs1_i   <= a;
    req_rs2_i   <= b;
    req_id_i    <= id;
    req_kill_i  <= kill;
    @(negedge clk_i);
    while (!req_ready_o) @(negedge clk_i);
    @(posedge clk_i);
    req_valid_i <= 1'b0;
    reqs_sent++;
  endtask

  task automatic random_req(input int i);
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] instr;
    rng = xorshift32(rng);
    r = rng;
    rng = xorshift32(rng);
    a = rng;
    rng = xorshift32(rng);
    b = rng;
    case (r[2:0])
      3'd0: instr = enc_rtype(7'd0, xif_pkg::F3_SATADD, r[12:8], OPC);
      3'd1: instr = enc_rtype(7'd0, xif_pkg::F3_ABSDIFF, r[12:8], OPC);
      3'd2: instr = enc_rtype(7'd0, xif_pkg::F3_MINU, r[12:8], OPC);
      3'd3: instr = enc_itype(r[31:20], xif_pkg::F3_ROTRI, r[12:8], OPC);
      3'd4: instr = enc_itype(r[31:20], xif_pkg::F3_BREVI, r[12:8], OPC);
      3'd5: instr = enc_rtype(r[31:25], r[15:13], r[12:8], OPC);
      3'd6: instr = enc_rtype(7'd0, xif_pkg::F3_SATADD, r[12:8], r[22:16]);
      default: begin
        // Both operands large so the add saturates
        instr = enc_rtype(7'd0, xif_pkg::F3_SATADD, r[12:8], OPC);
        a = a | 32'h8000_0000;
        b = b | 32'h8000_0000;
      end
    endcase
    send_req(instr, a, b, i[xif_pkg::XIF_ID_W-1:0], r[7:5] == 3'd0);
  endtask

  task automatic drain(input int max_cycles);
    int n;
    n = 0;
    while (pending_cnt != 0 && n < max_cycles) begin
      @(negedge clk_i);
      n++;
    end
    @(posedge clk_i);
  endtask

  task automatic check_response();
    int id;
    int lat;
    id  = int'(rsp_id_o);
    lat = cyc - xfer_cyc[id];
    rsp_seen++;
    if (!exp_pending[id]) begin
      $display("[ERROR] %0t: response for id %0d which has no request outstanding", $time, id);
      value_errs++;
    end else begin
      if (rsp_accept_o !== exp_accept[id])
        report_mismatch("accept", id, 32'(rsp_accept_o), 32'(exp_accept[id]));
      if (rsp_killed_o !== exp_killed[id])
        report_mismatch("killed", id, 32'(rsp_killed_o), 32'(exp_killed[id]));
      if (rsp_we_o !== exp_we[id])
        report_mismatch("we", id, 32'(rsp_we_o), 32'(exp_we[id]));
      if (exp_we[id] && rsp_rd_o !== exp_rd[id])
        report_mismatch("rd", id, 32'(rsp_rd_o), 32'(exp_rd[id]));
      if (exp_we[id] && rsp_data_o !== exp_data[id])
        report_mismatch("data", id, rsp_data_o, exp_data[id]);
      // Reject or kill answers two cycles after the issue, three after the request
      if (exp_fixed_lat[id] && lat != 3)
        report_mismatch("latency", id, 32'(lat), 32'd3);
      if (exp_we[id] && lat < 4)
        report_mismatch("latency below 4", id, 32'(lat), 32'd4);
      exp_pending[id] = 1'b0;
      pending_cnt--;
    end
  endtask

  task automatic record_request();
    int id;
    logic [33:0] r;
    id = int'(req_id_i);
    r  = ref_result(req_instr_i, req_rs1_i, req_rs2_i);
    if (exp_pending[id]) begin
      $display("[ERROR] %0t: id %0d taken again before its response", $time, id);
      value_errs++;
    end else begin
      pending_cnt++;
    end
    exp_pending[id]   = 1'b1;
    exp_accept[id]    = r[33];
    exp_killed[id]    = req_kill_i;
    exp_we[id]        = r[32] && !req_kill_i;
    exp_rd[id]        = req_instr_i[11:7];
    exp_data[id]      = r[31:0];
    exp_fixed_lat[id] = check_lat && (req_kill_i || !r[33]);
    xfer_cyc[id]      = cyc;
  endtask

  // Inputs change only on rising edges, so the falling edge sees settled values
  always @(negedge clk_i) begin
    cyc = cyc + 1;
    if (!rst_i) begin
      if (rsp_valid_o) check_response();
      if (req_valid_i && req_ready_o) record_request();
    end
  end

  initial begin
    repeat (WATCHDOG_CYC) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles and the run did not finish", WATCHDOG_CYC);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    rst_i        = 1'b1;
    req_valid_i  = 1'b0;
    req_instr_i  = 32'd0;
    req_rs1_i    = 32'd0;
    req_rs2_i    = 32'd0;
    req_id_i     = '0;
    req_kill_i   = 1'b0;
    rng          = 32'h9d70;
    cyc          = 0;
    pending_cnt  = 0;
    value_errs   = 0;
    missing_errs = 0;
    reqs_sent    = 0;
    rsp_seen     = 0;
    check_lat    = 1'b0;
    for (int i = 0; i < NUM_IDS; i++) exp_pending[i] = 1'b0;
    repeat (3) @(posedge clk_i);
    rst_i <= 1'b0;

    // Each operation with its corner cases
    send_req(enc_rtype(7'd0, xif_pkg::F3_SATADD, 5'd3, OPC), 32'h1234, 32'h4321, 4'd0, 1'b0);
    send_req(enc_rtype(7'd0, xif_pkg::F3_SATADD, 5'd4, OPC), 32'hffff_0000, 32'h0001_0000,
             4'd1, 1'b0);
    send_req(enc_rtype(7'd0, xif_pkg::F3_ABSDIFF, 5'd5, OPC), 32'd100, 32'd30, 4'd2, 1'b0);
    send_req(enc_rtype(7'd0, xif_pkg::F3_ABSDIFF, 5'd6, OPC), 32'd30, 32'hffff_fff0, 4'd3, 1'b0);
    send_req(enc_rtype(7'd0, xif_pkg::F3_MINU, 5'd7, OPC), 32'h8000_0001, 32'h7fff_ffff,
             4'd4, 1'b0);
    send_req(enc_itype(12'h000, xif_pkg::F3_ROTRI, 5'd8, OPC), 32'hdead_beef, 32'd0, 4'd5, 1'b0);
    send_req(enc_itype(12'h01f, xif_pkg::F3_ROTRI, 5'd9, OPC), 32'hdead_beef, 32'd0, 4'd6, 1'b0);
    send_req(enc_itype(12'h0a7, xif_pkg::F3_ROTRI, 5'd10, OPC), 32'h1234_5678, 32'd0,
             4'd7, 1'b0);
    send_req(enc_itype(12'h5a5, xif_pkg::F3_BREVI, 5'd31, OPC), 32'h0000_00f1, 32'd0,
             4'd8, 1'b0);
    drain(200);

    // Rejects and kills one at a time on an empty pipeline
    check_lat = 1'b1;
    send_req(enc_rtype(7'd0, xif_pkg::F3_SATADD, 5'd1, 7'b0110011), 32'd1, 32'd2, 4'd9, 1'b0);
    drain(50);
    send_req(enc_rtype(7'd0, 3'b011, 5'd1, OPC), 32'd1, 32'd2, 4'd10, 1'b0);
    drain(50);
    send_req(enc_rtype(7'd0, 3'b110, 5'd1, OPC), 32'd1, 32'd2, 4'd11, 1'b0);
    drain(50);
    send_req(enc_rtype(7'h20, xif_pkg::F3_MINU, 5'd1, OPC), 32'd1, 32'd2, 4'd12, 1'b0);
    drain(50);
    send_req(enc_rtype(7'd0, xif_pkg::F3_SATADD, 5'd2, OPC), 32'd5, 32'd6, 4'd13, 1'b1);
    drain(50);
    send_req(enc_itype(12'h004, xif_pkg::F3_ROTRI, 5'd2, OPC), 32'd5, 32'd6, 4'd14, 1'b1);
    drain(50);
    check_lat = 1'b0;

    // Second request on id 5 must wait for the first response
    send_req(enc_rtype(7'd0, xif_pkg::F3_ABSDIFF, 5'd12, OPC), 32'd7, 32'd9, 4'd5, 1'b0);
    send_req(enc_rtype(7'd0, xif_pkg::F3_MINU, 5'd13, OPC), 32'd7, 32'd9, 4'd5, 1'b0);
    drain(100);

    for (int i = 0; i < NUM_RANDOM; i++) random_req(i);
    drain(400);

    for (int i = 0; i < NUM_IDS; i++) begin
      if (exp_pending[i]) begin
        $display("No response ever arrived for id %0d", i);
        missing_errs++;
      end
    end
    $display("Errors: %0d value, %0d missing (%0d requests, %0d responses)",
             value_errs, missing_errs, reqs_sent, rsp_seen);
    if (value_errs == 0 && missing_errs == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* list.f */
verilog/xif_pkg.sv
verilog/xif_result_queue.sv
verilog/xif_copro_unit.sv
verilog/xif_version_adapter.sv
verilog/xif_offload_ctrl.sv
verilog/xif_offload_top.sv
bench/tb_xif_offload.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the XIF offload testbench with Verilator, run it and grade the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_xif_offload \
  -o sim_tb > build.log 2>&1 \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || { echo "Build or simulation step failed, see build.log and sim.log"; exit 1; }

grep -q "ALL CHECKS PASSED" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }
